//--- Makefile
# Verilator build and run for the asymmetric FIFO

VERILATOR ?= verilator
TOP       ?= tb_fifo_top
LINT_TOP  ?= fifo_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= No errors

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(EXE) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
rtl/fifo_pkg.sv
rtl/fifo_mem_bank.sv
rtl/ram_2p_asym.sv
rtl/fifo_sync_asym.sv
rtl/fifo_top.sv
test/tb_fifo_top.sv

//--- rtl/fifo_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_mem_bank (
   input  wire logic                clk_i,
   input  fifo_pkg::mem_wr_t        wr_i,
   input  fifo_pkg::mem_rd_t        rd_i,
   output fifo_pkg::lane_data_t     data_o
);

   localparam int DEPTH = 2 ** fifo_pkg::BANK_ADDR_W;

   // storage array, contents undefined after reset
   fifo_pkg::lane_data_t mem [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // read port, output register holds between reads
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         data_o <= mem[rd_i.addr];
      end
   end

endmodule

`default_nettype wire

//--- rtl/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // port widths, write side is the narrow one
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;

   // addresses count bytes
   localparam int ADDR_W = 6;

   // one bank per byte lane of the read word
   localparam int N_LANES = R_DATA_W / W_DATA_W;
   localparam int LANE_SEL_W = $clog2(N_LANES);
   localparam int BANK_ADDR_W = ADDR_W - LANE_SEL_W;

   // capacity in bytes
   localparam int FIFO_SIZE = 2 ** ADDR_W;

   typedef logic [W_DATA_W-1:0] w_data_t;
   typedef logic [R_DATA_W-1:0] r_data_t;
   typedef logic [W_DATA_W-1:0] lane_data_t;

   // byte pointer and word pointer
   typedef logic [ADDR_W-1:0] w_addr_t;
   typedef logic [BANK_ADDR_W-1:0] r_addr_t;
   typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

   // one extra bit so a full FIFO reads 64
   typedef logic [ADDR_W:0] level_t;

   // write bus of a single lane
   typedef struct packed {
      logic en;
      bank_addr_t addr;
      lane_data_t data;
   } mem_wr_t;

   // read request of a single lane
   typedef struct packed {
      logic en;
      bank_addr_t addr;
   } mem_rd_t;

endpackage

`default_nettype wire

//--- rtl/fifo_sync_asym.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_sync_asym (
   input  wire logic                clk_i,
   input  wire logic                arst_n_i,
   input  wire logic                rst_i,

   // write port
   input  wire logic                w_en_i,
   input  fifo_pkg::w_data_t        w_data_i,
   output logic                     w_full_o,

   // read port
   input  wire logic                r_en_i,
   output fifo_pkg::r_data_t        r_data_o,
   output logic                     r_empty_o,

   // fill level in bytes
   output fifo_pkg::level_t         level_o,

   // external banks
   output fifo_pkg::mem_wr_t        mem_wr_o      [fifo_pkg::N_LANES],
   output fifo_pkg::mem_rd_t        mem_rd_o      [fifo_pkg::N_LANES],
   input  fifo_pkg::lane_data_t     mem_rd_data_i [fifo_pkg::N_LANES]
);

   logic                w_en_int;
   logic                r_en_int;
   fifo_pkg::w_addr_t   w_addr;
   fifo_pkg::r_addr_t   r_addr;
   fifo_pkg::level_t    level;
   fifo_pkg::level_t    level_nxt;
   logic                r_empty_nxt;
   logic                w_full_nxt;

   // drop writes when full and reads when empty
   assign w_en_int = w_en_i && !w_full_o;
   assign r_en_int = r_en_i && !r_empty_o;

   // byte write pointer
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_addr <= '0;
      end else if (rst_i) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   // word read pointer
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_addr <= '0;
      end else if (rst_i) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // +1 per byte in, -4 per word out
   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + fifo_pkg::level_t'(1);
      end
      if (r_en_int) begin
         level_nxt = level_nxt - fifo_pkg::level_t'(fifo_pkg::N_LANES);
      end
   end

   // flags follow the next level so they line up with it
   assign r_empty_nxt = level_nxt < fifo_pkg::level_t'(fifo_pkg::N_LANES);
   assign w_full_nxt  = level_nxt > fifo_pkg::level_t'(fifo_pkg::FIFO_SIZE - 1);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level     <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else if (rst_i) begin
         level     <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level     <= level_nxt;
         r_empty_o <= r_empty_nxt;
         w_full_o  <= w_full_nxt;
      end
   end

   assign level_o = level;

   ram_2p_asym u_ram_2p_asym (
      .clk_i         (clk_i),
      .w_en_i        (w_en_int),
      .w_addr_i      (w_addr),
      .w_data_i      (w_data_i),
      .r_en_i        (r_en_int),
      .r_addr_i      (r_addr),
      .r_data_o      (r_data_o),
      .mem_wr_o      (mem_wr_o),
      .mem_rd_o      (mem_rd_o),
      .mem_rd_data_i (mem_rd_data_i)
   );

   a_level_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      level <= fifo_pkg::level_t'(fifo_pkg::FIFO_SIZE))
      else $error("level above capacity: %0d", level);

   a_flags_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(r_empty_o && w_full_o))
      else $error("empty and full both high");

endmodule

`default_nettype wire

//--- rtl/fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_top (
   input  wire logic                clk_i,
   input  wire logic                arst_n_i,
   input  wire logic                rst_i,

   input  wire logic                w_en_i,
   input  fifo_pkg::w_data_t        w_data_i,
   output logic                     w_full_o,

   input  wire logic                r_en_i,
   output fifo_pkg::r_data_t        r_data_o,
   output logic                     r_empty_o,

   output fifo_pkg::level_t         level_o
);

   fifo_pkg::mem_wr_t      mem_wr      [fifo_pkg::N_LANES];
   fifo_pkg::mem_rd_t      mem_rd      [fifo_pkg::N_LANES];
   fifo_pkg::lane_data_t   mem_rd_data [fifo_pkg::N_LANES];

   fifo_sync_asym u_fifo (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .rst_i         (rst_i),
      .w_en_i        (w_en_i),
      .w_data_i      (w_data_i),
      .w_full_o      (w_full_o),
      .r_en_i        (r_en_i),
      .r_data_o      (r_data_o),
      .r_empty_o     (r_empty_o),
      .level_o       (level_o),
      .mem_wr_o      (mem_wr),
      .mem_rd_o      (mem_rd),
      .mem_rd_data_i (mem_rd_data)
   );

   // one byte bank per lane
   for (genvar i = 0; i < fifo_pkg::N_LANES; i++) begin : g_bank
      fifo_mem_bank u_bank (
         .clk_i  (clk_i),
         .wr_i   (mem_wr[i]),
         .rd_i   (mem_rd[i]),
         .data_o (mem_rd_data[i])
      );
   end

endmodule

`default_nettype wire

//--- rtl/ram_2p_asym.sv
`timescale 1ns/1ps
`default_nettype none

module ram_2p_asym (
   input  wire logic                clk_i,

   // narrow write side
   input  wire logic                w_en_i,
   input  fifo_pkg::w_addr_t        w_addr_i,
   input  fifo_pkg::w_data_t        w_data_i,

   // wide read side
   input  wire logic                r_en_i,
   input  fifo_pkg::r_addr_t        r_addr_i,
   output fifo_pkg::r_data_t        r_data_o,

   // lane banks
   output fifo_pkg::mem_wr_t        mem_wr_o      [fifo_pkg::N_LANES],
   output fifo_pkg::mem_rd_t        mem_rd_o      [fifo_pkg::N_LANES],
   input  fifo_pkg::lane_data_t     mem_rd_data_i [fifo_pkg::N_LANES]
);

   logic [fifo_pkg::LANE_SEL_W-1:0] w_lane;
   fifo_pkg::bank_addr_t            w_bank_addr;
   logic [fifo_pkg::N_LANES-1:0]    lane_w_en;

   // low bits pick the lane, the rest is the row inside the bank
   assign w_lane      = w_addr_i[fifo_pkg::LANE_SEL_W-1:0];
   assign w_bank_addr = w_addr_i[fifo_pkg::ADDR_W-1:fifo_pkg::LANE_SEL_W];

   // one-hot lane decode
   always_comb begin
      for (int i = 0; i < fifo_pkg::N_LANES; i++) begin
         lane_w_en[i] = w_en_i && (w_lane == i[fifo_pkg::LANE_SEL_W-1:0]);
      end
   end

   // write buses, address and data go to every lane
   always_comb begin
      for (int i = 0; i < fifo_pkg::N_LANES; i++) begin
         mem_wr_o[i].en   = lane_w_en[i];
         mem_wr_o[i].addr = w_bank_addr;
         mem_wr_o[i].data = w_data_i;
      end
   end

   // all lanes read the same row
   always_comb begin
      for (int i = 0; i < fifo_pkg::N_LANES; i++) begin
         mem_rd_o[i].en   = r_en_i;
         mem_rd_o[i].addr = r_addr_i;
      end
   end

   // lane 0 is the oldest byte, so it lands in the low byte
   always_comb begin
      for (int i = 0; i < fifo_pkg::N_LANES; i++) begin
         r_data_o[i*fifo_pkg::W_DATA_W +: fifo_pkg::W_DATA_W] = mem_rd_data_i[i];
      end
   end

   // a byte write never touches more than one bank
   a_one_lane_w: assert property (@(posedge clk_i) $onehot0(lane_w_en))
      else $error("more than one lane write enable high: %b", lane_w_en);

endmodule

`default_nettype wire

//--- test/tb_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fifo_top;

   logic                  clk;
   logic                  arst_n;
   logic                  rst;
   logic                  w_en;
   fifo_pkg::w_data_t     w_data;
   logic                  w_full;
   logic                  r_en;
   fifo_pkg::r_data_t     r_data;
   logic                  r_empty;
   fifo_pkg::level_t      level;

   // bytes the FIFO should hold, oldest first
   fifo_pkg::w_data_t     model_q [$];
   fifo_pkg::r_data_t     last_word;
   int                    errors;
   int                    checks;
   int                    tests;

   fifo_top DUT (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .rst_i     (rst),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_full_o  (w_full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .level_o   (level)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // inputs change 2 ns after the edge, outputs are read there too
   task automatic next_cycle;
      @(posedge clk);
      #2;
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
         errors++;
      end
   endtask

   // flags and level follow from the byte count alone
   task automatic check_flags;
      check_val("level_o", 32'(model_q.size()), 32'(level));
      check_val("r_empty_o", 32'(model_q.size() < fifo_pkg::N_LANES), 32'(r_empty));
      check_val("w_full_o", 32'(model_q.size() > fifo_pkg::FIFO_SIZE - 1), 32'(w_full));
   endtask

   task automatic wait_empty_flag(input logic exp, input int limit);
      int n;
      n = 0;
      while (r_empty !== exp && n < limit) begin
         next_cycle();
         n++;
      end
      checks++;
      assert (r_empty === exp) else begin
         $display("timeout: r_empty_o did not reach %b within %0d cycles", exp, limit);
         errors++;
      end
   endtask

   // first byte in goes to the low byte of the word
   function automatic fifo_pkg::r_data_t model_pop_word();
      fifo_pkg::r_data_t word;
      word = '0;
      for (int i = 0; i < fifo_pkg::N_LANES; i++) begin
         word[i*fifo_pkg::W_DATA_W +: fifo_pkg::W_DATA_W] = model_q.pop_front();
      end
      return word;
   endfunction

   task automatic push_byte(input fifo_pkg::w_data_t b);
      logic accepted;
      accepted = model_q.size() < fifo_pkg::FIFO_SIZE;
      w_en   = 1'b1;
      w_data = b;
      next_cycle();
      w_en = 1'b0;
      if (accepted) begin
         model_q.push_back(b);
      end
      check_flags();
   endtask

   task automatic pop_word;
      logic               accepted;
      accepted = model_q.size() >= fifo_pkg::N_LANES;
      // a dropped read leaves the output register alone
      if (accepted) begin
         last_word = model_pop_word();
      end
      r_en = 1'b1;
      next_cycle();
      r_en = 1'b0;
      check_val("r_data_o", last_word, r_data);
      check_flags();
   endtask

   task automatic push_pop(input fifo_pkg::w_data_t b);
      last_word = model_pop_word();
      model_q.push_back(b);
      w_en   = 1'b1;
      w_data = b;
      r_en   = 1'b1;
      next_cycle();
      w_en = 1'b0;
      r_en = 1'b0;
      check_val("r_data_o", last_word, r_data);
      check_flags();
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   task automatic test_reset;
      int e0;
      e0 = errors;
      wait_empty_flag(1'b1, 4);
      check_flags();
      report_test("reset", e0);
   endtask

   task automatic test_byte_order;
      int e0;
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      pop_word();
      pop_word();
      report_test("byte order", e0);
   endtask

   task automatic test_empty_threshold;
      int e0;
      e0 = errors;
      for (int i = 0; i < 3; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      // too few bytes for a word
      pop_word();
      push_byte(fifo_pkg::w_data_t'($urandom));
      pop_word();
      report_test("empty threshold", e0);
   endtask

   task automatic test_full;
      int e0;
      e0 = errors;
      for (int i = 0; i < fifo_pkg::FIFO_SIZE; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      // this one is dropped
      push_byte(8'ha5);
      for (int i = 0; i < fifo_pkg::FIFO_SIZE / fifo_pkg::N_LANES; i++) begin
         pop_word();
      end
      report_test("full", e0);
   endtask

   task automatic test_simultaneous;
      int e0;
      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      push_pop(fifo_pkg::w_data_t'($urandom));
      push_byte(fifo_pkg::w_data_t'($urandom));
      pop_word();
      report_test("simultaneous read and write", e0);
   endtask

   task automatic test_clear;
      int e0;
      e0 = errors;
      for (int i = 0; i < 5; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      rst = 1'b1;
      next_cycle();
      rst = 1'b0;
      model_q.delete();
      check_flags();
      for (int i = 0; i < 4; i++) begin
         push_byte(fifo_pkg::w_data_t'($urandom));
      end
      pop_word();
      report_test("clear", e0);
   endtask

   initial begin
      arst_n    = 1'b0;
      rst       = 1'b0;
      w_en      = 1'b0;
      w_data    = '0;
      r_en      = 1'b0;
      last_word = '0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      void'($urandom(32'h862b_58a0));
      repeat (5) @(posedge clk);
      #2;
      arst_n = 1'b1;
      test_reset();
      test_byte_order();
      test_empty_threshold();
      test_full();
      test_simultaneous();
      test_clear();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
